// File: de0_nano_pkg.sv
// shared sizes and encodings for the board I/O block
// one clock domain only, every width here is fixed at compile time
// register map is word addressed, eight slots, no byte enables
// GPIO width itself is a module parameter, set at the top level

package de0_nano_pkg;

	// ========================================================================
	// bus and port sizes
	// ========================================================================
	localparam int BUS_WIDTH     = 32;   // host data word
	localparam int ADDR_WIDTH    = 3;    // word address, eight registers
	localparam int NUM_KEYS      = 2;    // push buttons on the board
	localparam int LED_COUNT     = 8;    // panel LEDs
	localparam int LED_REG_WIDTH = 7;    // host-writable LED bits, LED 0 is not writable

	// ========================================================================
	// register map
	// ========================================================================
	// first six slots keep the old I/O register order
	typedef enum logic [ADDR_WIDTH-1:0] {
		REG_GPIO0_OUT  = 3'd0,   // port 0 output data
		REG_GPIO0_OE   = 3'd1,   // port 0 output enable
		REG_GPIO0_IN   = 3'd2,   // port 0 readback, read only
		REG_GPIO1_OUT  = 3'd3,
		REG_GPIO1_OE   = 3'd4,
		REG_GPIO1_IN   = 3'd5,   // read only
		REG_LED        = 3'd6,   // LED bits 6..0
		REG_KEY_STATUS = 3'd7    // debounced buttons, read only
	} reg_addr_e;

	// ========================================================================
	// long-press outcome
	// ========================================================================
	// pattern 01 -> warm, 10 -> cold, 11 -> debug
	typedef enum logic [1:0] {
		REQ_NONE  = 2'd0,
		REQ_WARM  = 2'd1,
		REQ_COLD  = 2'd2,
		REQ_DEBUG = 2'd3
	} reset_req_e;

endpackage

// File: host_bus_if.sv
// host register bus between the top level and the register bank
// strobes are single cycle and qualified by chipsel, no wait states
// rdata is valid only while rd_valid is high, one cycle after the read

interface host_bus_if import de0_nano_pkg::*; ();

	logic                 chipsel;   // qualifies read and write
	logic                 read;      // read strobe
	logic                 write;     // write strobe
	reg_addr_e            address;   // word address
	logic [BUS_WIDTH-1:0] wdata;     // write data from host
	logic [BUS_WIDTH-1:0] rdata;     // registered readback
	logic                 rd_valid;  // one cycle after an accepted read

	// top level drives requests
	modport host (output chipsel, read, write, address, wdata,
		input rdata, rd_valid);

	// register bank answers
	modport bank (input chipsel, read, write, address, wdata,
		output rdata, rd_valid);

endinterface

// File: key_if.sv
// conditioned button state and reset request strobes
// buttons are active high once debounced; request strobes last one cycle
// at most one request strobe is high at any time

interface key_if import de0_nano_pkg::*; ();

	logic [NUM_KEYS-1:0] buttons;    // debounced, 1 = pressed
	logic                warm_req;   // key 0 long press
	logic                cold_req;   // key 1 long press
	logic                debug_req;  // both keys long press

	modport source (output buttons, warm_req, cold_req, debug_req);

	// bank reads buttons, LED merge watches the strobes
	modport sink (input buttons, warm_req, cold_req, debug_req);

endinterface

// File: key_conditioner.sv
// button synchroniser, debouncer and long-press detector
// key pins are active low and asynchronous to fpga_clk_50
// the debounced level follows only after DEBOUNCE_CYCLES of steady input
// one request per press: releasing or changing the pattern rearms it
// written for two buttons, the pattern decode assumes NUM_KEYS = 2

module key_conditioner import de0_nano_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 50000,
	parameter int HOLD_CYCLES     = 25000000
) (
	input  logic                fpga_clk_50,
	input  logic                rst,
	input  logic [NUM_KEYS-1:0] key,     // raw, active low
	key_if.source               keys
);

	localparam int DB_W   = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

	logic [NUM_KEYS-1:0] key_meta;       // first sync stage
	logic [NUM_KEYS-1:0] key_sync;       // second sync stage, active high
	logic [NUM_KEYS-1:0] db_level;       // debounced pattern
	logic [DB_W-1:0]     db_cnt [NUM_KEYS];
	logic [NUM_KEYS-1:0] db_prev;        // pattern one cycle back
	logic [HOLD_W-1:0]   hold_cnt;
	reset_req_e          pat_req;        // request the current pattern maps to
	reset_req_e          req_fired;      // what this press already raised
	logic                fire;

	// ========================================================================
	// synchroniser, inverted so 1 = pressed
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			key_meta <= '0;
			key_sync <= '0;
		end else begin
			key_meta <= ~key;
			key_sync <= key_meta;
		end
	end

	// ========================================================================
	// debounce, one counter per button
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			db_level <= '0;
			for (int i = 0; i < NUM_KEYS; i++) begin
				db_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_KEYS; i++) begin
				if (key_sync[i] == db_level[i]) begin
					db_cnt[i] <= '0;                     // steady, nothing pending
				end else if (db_cnt[i] == DB_W'(DEBOUNCE_CYCLES - 1)) begin
					db_level[i] <= key_sync[i];          // differed long enough
					db_cnt[i]   <= '0;
				end else begin
					db_cnt[i] <= db_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign keys.buttons = db_level;

	// pattern to request
	always_comb begin
		case (db_level)
			2'b01:   pat_req = REQ_WARM;
			2'b10:   pat_req = REQ_COLD;
			2'b11:   pat_req = REQ_DEBUG;
			default: pat_req = REQ_NONE;
		endcase
	end

	// fires once when the count lands, req_fired blocks repeats
	assign fire = (hold_cnt == HOLD_W'(HOLD_CYCLES - 1)) && (db_level == db_prev) &&
		(req_fired == REQ_NONE) && (pat_req != REQ_NONE);

	// ========================================================================
	// long-press hold counter, shared by both buttons
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			db_prev        <= '0;
			hold_cnt       <= '0;
			req_fired      <= REQ_NONE;
			keys.warm_req  <= 1'b0;
			keys.cold_req  <= 1'b0;
			keys.debug_req <= 1'b0;
		end else begin
			db_prev <= db_level;
			if (db_level != db_prev || pat_req == REQ_NONE) begin
				hold_cnt  <= '0;                       // restart on any change
				req_fired <= REQ_NONE;
			end else if (hold_cnt != HOLD_W'(HOLD_CYCLES - 1)) begin
				hold_cnt <= hold_cnt + 1'b1;           // saturates at the limit
			end else if (fire) begin
				req_fired <= pat_req;
			end
			keys.warm_req  <= fire && (pat_req == REQ_WARM);
			keys.cold_req  <= fire && (pat_req == REQ_COLD);
			keys.debug_req <= fire && (pat_req == REQ_DEBUG);
		end
	end

endmodule

// File: gpio_reg_bank.sv
// host register bank for two pin ports, the LED bits and key status
// writes land at the strobe edge, reads answer one cycle later
// a read and a write to the same slot in one cycle returns the old value
// pin inputs pass two sync flops before they can be read back
// GPIO_WIDTH must not exceed BUS_WIDTH, upper bits read as zero

module gpio_reg_bank import de0_nano_pkg::*; #(
	parameter int GPIO_WIDTH = 32
) (
	input  logic                     fpga_clk_50,
	input  logic                     rst,
	host_bus_if.bank                 bus,
	key_if.sink                      keys,
	input  logic [GPIO_WIDTH-1:0]    gpio0_in,
	input  logic [GPIO_WIDTH-1:0]    gpio1_in,
	output logic [GPIO_WIDTH-1:0]    gpio0_out,
	output logic [GPIO_WIDTH-1:0]    gpio0_oe,
	output logic [GPIO_WIDTH-1:0]    gpio1_out,
	output logic [GPIO_WIDTH-1:0]    gpio1_oe,
	output logic [LED_REG_WIDTH-1:0] led_bits
);

	logic                  wr_en;        // accepted write
	logic                  rd_en;        // accepted read
	logic [GPIO_WIDTH-1:0] gpio0_meta;
	logic [GPIO_WIDTH-1:0] gpio0_sync;
	logic [GPIO_WIDTH-1:0] gpio1_meta;
	logic [GPIO_WIDTH-1:0] gpio1_sync;
	logic [BUS_WIDTH-1:0]  rd_word;      // readback mux output

	assign wr_en = bus.chipsel && bus.write;
	assign rd_en = bus.chipsel && bus.read;

	// ========================================================================
	// write decode
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			gpio0_out <= '0;
			gpio0_oe  <= '0;                 // pins start disabled
			gpio1_out <= '0;
			gpio1_oe  <= '0;
			led_bits  <= '0;
		end else if (wr_en) begin
			case (bus.address)
				REG_GPIO0_OUT: gpio0_out <= bus.wdata[GPIO_WIDTH-1:0];
				REG_GPIO0_OE:  gpio0_oe  <= bus.wdata[GPIO_WIDTH-1:0];
				REG_GPIO1_OUT: gpio1_out <= bus.wdata[GPIO_WIDTH-1:0];
				REG_GPIO1_OE:  gpio1_oe  <= bus.wdata[GPIO_WIDTH-1:0];
				REG_LED:       led_bits  <= bus.wdata[LED_REG_WIDTH-1:0];
				default: ;                       // read-only slots drop the write
			endcase
		end
	end

	// ========================================================================
	// pin input synchronisers
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			gpio0_meta <= '0;
			gpio0_sync <= '0;
			gpio1_meta <= '0;
			gpio1_sync <= '0;
		end else begin
			gpio0_meta <= gpio0_in;
			gpio0_sync <= gpio0_meta;
			gpio1_meta <= gpio1_in;
			gpio1_sync <= gpio1_meta;
		end
	end

	// ========================================================================
	// readback
	// ========================================================================
	// zero extend everything to the bus word
	always_comb begin
		case (bus.address)
			REG_GPIO0_OUT:  rd_word = BUS_WIDTH'(gpio0_out);
			REG_GPIO0_OE:   rd_word = BUS_WIDTH'(gpio0_oe);
			REG_GPIO0_IN:   rd_word = BUS_WIDTH'(gpio0_sync);
			REG_GPIO1_OUT:  rd_word = BUS_WIDTH'(gpio1_out);
			REG_GPIO1_OE:   rd_word = BUS_WIDTH'(gpio1_oe);
			REG_GPIO1_IN:   rd_word = BUS_WIDTH'(gpio1_sync);
			REG_LED:        rd_word = BUS_WIDTH'(led_bits);
			REG_KEY_STATUS: rd_word = BUS_WIDTH'(keys.buttons);
			default:        rd_word = '0;
		endcase
	end

	// rdata holds between reads
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			bus.rdata    <= '0;
			bus.rd_valid <= 1'b0;
		end else begin
			bus.rd_valid <= rd_en;           // exactly one cycle per read
			if (rd_en) begin
				bus.rdata <= rd_word;        // pre-write value on a collision
			end
		end
	end

endmodule

// File: panel_led_merge.sv
// panel LED driver
// LEDs 5..1 follow LED bits 4..0, LEDs 7 and 6 show bits 6 and 5 inverted
// LED 0 is a pulse stretcher on the reset request strobes
// a new request while lit restarts the full stretch

module panel_led_merge import de0_nano_pkg::*; #(
	parameter int LED_STRETCH = 12500000
) (
	input  logic                     fpga_clk_50,
	input  logic                     rst,
	input  logic [LED_REG_WIDTH-1:0] led_bits,
	key_if.sink                      keys,
	output logic [LED_COUNT-1:0]     led
);

	localparam int STR_W = $clog2(LED_STRETCH + 1);

	logic             any_req;           // any of the three strobes
	logic [STR_W-1:0] stretch_cnt;       // cycles of LED 0 left

	assign any_req = keys.warm_req || keys.cold_req || keys.debug_req;

	// ========================================================================
	// request stretcher
	// ========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			stretch_cnt <= '0;
		end else if (any_req) begin
			stretch_cnt <= STR_W'(LED_STRETCH);  // lit from the next cycle
		end else if (stretch_cnt != '0) begin
			stretch_cnt <= stretch_cnt - 1'b1;
		end
	end

	// ========================================================================
	// output map
	// ========================================================================
	assign led[7:6] = ~led_bits[6:5];        // inverted, so on after reset
	assign led[5:1] = led_bits[4:0];
	assign led[0]   = (stretch_cnt != '0);

endmodule

// File: de0_nano_io.sv
// board I/O top: host register bus, two pin ports, buttons and panel LEDs
// single clock fpga_clk_50, rst synchronous and active high
// pins come as separate out, enable and in vectors, tristate is outside
// key inputs are active low; the hps_*_reset outputs are one-cycle strobes
// timing parameters default to a 50 MHz clock

module de0_nano_io import de0_nano_pkg::*; #(
	parameter int GPIO_WIDTH      = 32,
	parameter int DEBOUNCE_CYCLES = 50000,     // 1 ms
	parameter int HOLD_CYCLES     = 25000000,  // 0.5 s long press
	parameter int LED_STRETCH     = 12500000   // 0.25 s
) (
	input  logic                  fpga_clk_50,
	input  logic                  rst,
	// host register bus
	input  logic                  hm_chipsel,
	input  logic                  hm_read,
	input  logic                  hm_write,
	input  logic [ADDR_WIDTH-1:0] hm_address,
	input  logic [BUS_WIDTH-1:0]  hm_datai,
	output logic [BUS_WIDTH-1:0]  hm_datao,
	output logic                  hm_rd_valid,
	// board pins
	input  logic [NUM_KEYS-1:0]   key,
	input  logic [GPIO_WIDTH-1:0] gpio0_in,
	input  logic [GPIO_WIDTH-1:0] gpio1_in,
	output logic [GPIO_WIDTH-1:0] gpio0_out,
	output logic [GPIO_WIDTH-1:0] gpio0_oe,
	output logic [GPIO_WIDTH-1:0] gpio1_out,
	output logic [GPIO_WIDTH-1:0] gpio1_oe,
	output logic [LED_COUNT-1:0]  led,
	// reset requests toward the processor side
	output logic                  hps_warm_reset,
	output logic                  hps_cold_reset,
	output logic                  hps_debug_reset
);

	logic [LED_REG_WIDTH-1:0] led_bits;      // bank to LED merge

	host_bus_if bus_if ();
	key_if      key_bus ();

	// ========================================================================
	// host bus onto the interface
	// ========================================================================
	assign bus_if.chipsel = hm_chipsel;
	assign bus_if.read    = hm_read;
	assign bus_if.write   = hm_write;
	assign bus_if.address = reg_addr_e'(hm_address);
	assign bus_if.wdata   = hm_datai;
	assign hm_datao       = bus_if.rdata;
	assign hm_rd_valid    = bus_if.rd_valid;

	assign hps_warm_reset  = key_bus.warm_req;
	assign hps_cold_reset  = key_bus.cold_req;
	assign hps_debug_reset = key_bus.debug_req;

	// ========================================================================
	// submodules
	// ========================================================================
	key_conditioner #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.HOLD_CYCLES     (HOLD_CYCLES)
	) u_key_conditioner (
		.fpga_clk_50 (fpga_clk_50),
		.rst         (rst),
		.key         (key),
		.keys        (key_bus)
	);

	gpio_reg_bank #(
		.GPIO_WIDTH (GPIO_WIDTH)
	) u_gpio_reg_bank (
		.fpga_clk_50 (fpga_clk_50),
		.rst         (rst),
		.bus         (bus_if),
		.keys        (key_bus),              // key status readback
		.gpio0_in    (gpio0_in),
		.gpio1_in    (gpio1_in),
		.gpio0_out   (gpio0_out),
		.gpio0_oe    (gpio0_oe),
		.gpio1_out   (gpio1_out),
		.gpio1_oe    (gpio1_oe),
		.led_bits    (led_bits)
	);

	panel_led_merge #(
		.LED_STRETCH (LED_STRETCH)
	) u_panel_led_merge (
		.fpga_clk_50 (fpga_clk_50),
		.rst         (rst),
		.led_bits    (led_bits),
		.keys        (key_bus),
		.led         (led)
	);

endmodule

// File: de0_nano_io_props.sv
// timing rules of the board I/O block, bound into de0_nano_io
// all checks are off while rst is high
// LED_STRETCH is taken from the bound instance so both agree
// fail_cnt counts failed assertions for the end-of-run result

module de0_nano_io_props #(
	parameter int LED_STRETCH = 16
) (
	input logic fpga_clk_50,
	input logic rst,
	input logic hm_chipsel,
	input logic hm_read,
	input logic hm_rd_valid,
	input logic hps_warm_reset,
	input logic hps_cold_reset,
	input logic hps_debug_reset,
	input logic led0
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LIT_W = $clog2(LED_STRETCH + 1);

	int         fail_cnt = 0;        // polled by the testbench at the end
	logic       any_req;
	logic [LIT_W-1:0] lit_left;      // cycles LED 0 must still be lit

	assign any_req = hps_warm_reset || hps_cold_reset || hps_debug_reset;

	// expected LED 0 window, restarts on every strobe
	always_ff @(posedge fpga_clk_50) begin
		if (rst) begin
			lit_left <= '0;
		end else if (any_req) begin
			lit_left <= LIT_W'(LED_STRETCH);
		end else if (lit_left != '0) begin
			lit_left <= lit_left - 1'b1;
		end
	end

	// ========================================================================
	// bus handshake
	// ========================================================================
	a_rd_valid: assert property (@(posedge fpga_clk_50) disable iff (rst)
		hm_rd_valid == $past(hm_chipsel && hm_read))
		else begin
			$error("rd_valid does not match an accepted read one cycle earlier");
			fail_cnt++;
		end

	// ========================================================================
	// reset request strobes
	// ========================================================================
	a_warm_pulse: assert property (@(posedge fpga_clk_50) disable iff (rst)
		hps_warm_reset |=> !hps_warm_reset)
		else begin
			$error("warm reset strobe longer than one cycle");
			fail_cnt++;
		end

	a_cold_pulse: assert property (@(posedge fpga_clk_50) disable iff (rst)
		hps_cold_reset |=> !hps_cold_reset)
		else begin
			$error("cold reset strobe longer than one cycle");
			fail_cnt++;
		end

	a_debug_pulse: assert property (@(posedge fpga_clk_50) disable iff (rst)
		hps_debug_reset |=> !hps_debug_reset)
		else begin
			$error("debug reset strobe longer than one cycle");
			fail_cnt++;
		end

	a_one_strobe: assert property (@(posedge fpga_clk_50) disable iff (rst)
		$onehot0({hps_warm_reset, hps_cold_reset, hps_debug_reset}))
		else begin
			$error("more than one reset strobe high at once");
			fail_cnt++;
		end

	// lit exactly LED_STRETCH cycles after the last strobe
	a_led_stretch: assert property (@(posedge fpga_clk_50) disable iff (rst)
		led0 == (lit_left != '0))
		else begin
			$error("LED 0 does not follow the request stretch window");
			fail_cnt++;
		end

endmodule

bind de0_nano_io de0_nano_io_props #(
	.LED_STRETCH (LED_STRETCH)
) u_props (
	.fpga_clk_50     (fpga_clk_50),
	.rst             (rst),
	.hm_chipsel      (hm_chipsel),
	.hm_read         (hm_read),
	.hm_rd_valid     (hm_rd_valid),
	.hps_warm_reset  (hps_warm_reset),
	.hps_cold_reset  (hps_cold_reset),
	.hps_debug_reset (hps_debug_reset),
	.led0            (led[0])
);

// File: tb_de0_nano_io.sv
// testbench for the board I/O top, short debounce and hold times
// inputs change on the falling edge, outputs are sampled there too
// timing checks live in the bound props module, data checks here

module tb_de0_nano_io import de0_nano_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int GPIO_WIDTH      = 32;
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int HOLD_CYCLES     = 32;
	localparam int LED_STRETCH     = 16;
	localparam int CLK_PERIOD      = 40;
	localparam int PRESS_CYCLES    = 2 * DEBOUNCE_CYCLES + 2 * HOLD_CYCLES + LED_STRETCH + 40;
	localparam int RUN_CYCLES      = 216 + 8 * (DEBOUNCE_CYCLES + 8) + 3 * PRESS_CYCLES;

	logic                  fpga_clk_50 = 1'b0;
	logic                  rst, hm_chipsel, hm_read, hm_write, hm_rd_valid;
	logic [ADDR_WIDTH-1:0] hm_address;
	logic [BUS_WIDTH-1:0]  hm_datai, hm_datao;
	logic [NUM_KEYS-1:0]   key;                // active low
	logic [GPIO_WIDTH-1:0] gpio0_in, gpio1_in, gpio0_out, gpio0_oe, gpio1_out, gpio1_oe;
	logic [LED_COUNT-1:0]  led;
	logic                  hps_warm_reset, hps_cold_reset, hps_debug_reset;

	int seed = 40064;
	int test_errs, tests_passed, tests_failed;
	int warm_cnt, cold_cnt, debug_cnt;        // strobes seen since reset
	logic [BUS_WIDTH-1:0] shadow [8];         // expected register contents
	reg_addr_e wr_regs [5] = '{REG_GPIO0_OUT, REG_GPIO0_OE, REG_GPIO1_OUT,
		REG_GPIO1_OE, REG_LED};

	de0_nano_io #(
		.GPIO_WIDTH      (GPIO_WIDTH),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.HOLD_CYCLES     (HOLD_CYCLES),
		.LED_STRETCH     (LED_STRETCH)
	) u_de0_nano_io (.*);

	initial begin
		forever #(CLK_PERIOD / 2) fpga_clk_50 = ~fpga_clk_50;
	end

	// watchdog, twice the summed test lengths
	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", 2 * RUN_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	always @(negedge fpga_clk_50) begin
		if (!rst) begin
			warm_cnt  += hps_warm_reset;
			cold_cnt  += hps_cold_reset;
			debug_cnt += hps_debug_reset;
		end
	end

	// ========================================================================
	// check and bus helpers, all start and end on a falling edge
	// ========================================================================
	function automatic logic [BUS_WIDTH-1:0] reg_mask(input reg_addr_e a);
		if (a == REG_LED) return BUS_WIDTH'({LED_REG_WIDTH{1'b1}});
		return BUS_WIDTH'({GPIO_WIDTH{1'b1}});
	endfunction

	task automatic check_value(input string name, input logic [BUS_WIDTH-1:0] exp, act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		assert (cond) else begin
			$display("%s: %s", name, what);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished, %0d errors", name, test_errs);
		if (test_errs == 0) tests_passed++;
		else tests_failed++;
		test_errs = 0;
	endtask

	task automatic bus_write(input reg_addr_e a, input logic [BUS_WIDTH-1:0] d, input logic cs);
		hm_chipsel = cs;
		hm_write   = 1'b1;
		hm_address = a;
		hm_datai   = d;
		@(negedge fpga_clk_50);
		hm_chipsel = 1'b0;
		hm_write   = 1'b0;
	endtask

	// data is due exactly one cycle after the strobe
	task automatic read_expect(input string name, input reg_addr_e a,
		input logic [BUS_WIDTH-1:0] exp);
		hm_chipsel = 1'b1;
		hm_read    = 1'b1;
		hm_address = a;
		@(negedge fpga_clk_50);
		hm_chipsel = 1'b0;
		hm_read    = 1'b0;
		check_true(name, hm_rd_valid === 1'b1, "rd_valid missing one cycle after a read");
		check_value(name, exp, hm_datao);
	endtask

	task automatic check_pins(input string name);
		check_value(name, shadow[REG_GPIO0_OUT], BUS_WIDTH'(gpio0_out));
		check_value(name, shadow[REG_GPIO0_OE], BUS_WIDTH'(gpio0_oe));
		check_value(name, shadow[REG_GPIO1_OUT], BUS_WIDTH'(gpio1_out));
		check_value(name, shadow[REG_GPIO1_OE], BUS_WIDTH'(gpio1_oe));
		check_value(name, {~shadow[REG_LED][6:5], shadow[REG_LED][4:0]}, BUS_WIDTH'(led[7:1]));
	endtask

	// hold a key pattern past the hold time, expect one strobe of one kind
	task automatic long_press(input string name, input logic [1:0] pattern,
		input int exp_w, exp_c, exp_d);
		int w0, c0, d0, cycles;
		w0 = warm_cnt;
		c0 = cold_cnt;
		d0 = debug_cnt;
		cycles = 0;
		key = ~pattern;
		while (!(hps_warm_reset || hps_cold_reset || hps_debug_reset) &&
			cycles < PRESS_CYCLES) begin
			@(negedge fpga_clk_50);
			cycles++;
		end
		check_true(name, hps_warm_reset || hps_cold_reset || hps_debug_reset,
			"no reset request seen while the keys were held");
		repeat (HOLD_CYCLES + 8) @(negedge fpga_clk_50);     // still held, no repeat
		key = '1;
		repeat (DEBOUNCE_CYCLES + LED_STRETCH + 4) @(negedge fpga_clk_50);
		check_value(name, exp_w, warm_cnt - w0);
		check_value(name, exp_c, cold_cnt - c0);
		check_value(name, exp_d, debug_cnt - d0);
		check_value(name, 0, led[0]);
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		logic [BUS_WIDTH-1:0] d;
		int len;
		rst = 1'b1;
		{hm_chipsel, hm_read, hm_write} = '0;
		hm_address = '0;
		hm_datai   = '0;
		key        = '1;                        // released
		gpio0_in   = '0;
		gpio1_in   = '0;
		{test_errs, tests_passed, tests_failed, warm_cnt, cold_cnt, debug_cnt} = '0;
		for (int i = 0; i < 8; i++) shadow[i] = '0;
		repeat (16) @(negedge fpga_clk_50);
		rst = 1'b0;

		check_value("reset_state", 2'b11, led[7:6]);
		check_value("reset_state", 0, led[0]);
		for (int i = 0; i < 8; i++) read_expect("reset_state", reg_addr_e'(i), '0);
		finish_test("reset_state");

		for (int n = 0; n < 6; n++) begin
			foreach (wr_regs[i]) begin
				d = $random(seed);
				shadow[wr_regs[i]] = d & reg_mask(wr_regs[i]);
				bus_write(wr_regs[i], d, 1'b1);
				check_pins("reg_readback");            // outputs follow next cycle
				read_expect("reg_readback", wr_regs[i], shadow[wr_regs[i]]);
			end
		end
		finish_test("reg_readback");

		foreach (wr_regs[i]) bus_write(wr_regs[i], $random(seed), 1'b0);
		hm_read = 1'b1;                          // chipsel stays low
		@(negedge fpga_clk_50);
		hm_read = 1'b0;
		check_true("no_select", hm_rd_valid === 1'b0, "rd_valid raised without chipsel");
		bus_write(REG_GPIO0_IN, $random(seed), 1'b1);
		bus_write(REG_GPIO1_IN, $random(seed), 1'b1);
		bus_write(REG_KEY_STATUS, $random(seed), 1'b1);
		check_pins("no_select");
		read_expect("no_select", REG_GPIO0_IN, BUS_WIDTH'(gpio0_in));
		read_expect("no_select", REG_GPIO1_IN, BUS_WIDTH'(gpio1_in));
		read_expect("no_select", REG_KEY_STATUS, '0);
		finish_test("no_select");

		for (int n = 0; n < 4; n++) begin
			gpio0_in = $random(seed);
			gpio1_in = $random(seed);
			repeat (3) @(negedge fpga_clk_50);   // through both sync flops
			read_expect("pin_input", REG_GPIO0_IN, BUS_WIDTH'(gpio0_in));
			read_expect("pin_input", REG_GPIO1_IN, BUS_WIDTH'(gpio1_in));
		end
		finish_test("pin_input");

		for (int n = 0; n < 6; n++) begin
			len = 1 + ({$random(seed)} % (DEBOUNCE_CYCLES - 2));
			key = ~(2'(1 + ({$random(seed)} % 3)));
			repeat (len) @(negedge fpga_clk_50);
			key = '1;
			repeat (4) @(negedge fpga_clk_50);
			read_expect("key_debounce", REG_KEY_STATUS, '0);
		end
		key = 2'b10;                             // key 0 down
		repeat (DEBOUNCE_CYCLES + 4) @(negedge fpga_clk_50);
		read_expect("key_debounce", REG_KEY_STATUS, 32'h1);
		key = '1;
		repeat (DEBOUNCE_CYCLES + 4) @(negedge fpga_clk_50);
		read_expect("key_debounce", REG_KEY_STATUS, '0);
		check_value("key_debounce", 0, warm_cnt + cold_cnt + debug_cnt);
		finish_test("key_debounce");

		long_press("long_press_warm", 2'b01, 1, 0, 0);
		long_press("long_press_cold", 2'b10, 0, 1, 0);
		long_press("long_press_debug", 2'b11, 0, 0, 1);
		finish_test("long_press");

		$display("tests passed %0d, tests failed %0d, assertion failures %0d",
			tests_passed, tests_failed, u_de0_nano_io.u_props.fail_cnt);
		if (tests_failed == 0 && u_de0_nano_io.u_props.fail_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
de0_nano_pkg.sv
host_bus_if.sv
key_if.sv
key_conditioner.sv
gpio_reg_bank.sv
panel_led_merge.sv
de0_nano_io.sv
de0_nano_io_props.sv
tb_de0_nano_io.sv
